/* board_cfg.svh */
// ----------------------------------------------------------
// build-time constants for the board register block
// include where timer lengths or version words are needed
// ----------------------------------------------------------
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// log2 of sysclk cycles per timer tick
`define WIDTH_WATCHDOG 4

// settle ticks after motor voltage becomes good
`define MV_GOOD_TICKS 8

// stable cycles before a filtered switch input follows
`define DEBOUNCE_CYCLES 8

// length of the internal reset pulse on a soft reset
`define SOFT_RESET_CYCLES 32

// version words, read back by the host
`define BOARD_VERSION 32'h514C4131
`define FW_VERSION    32'h00000004

`endif

/* board_pkg.sv */
// ----------------------------------------------------------
// types and register offsets of the board register block
// imported by every design unit that touches the host bus
// ----------------------------------------------------------
`default_nettype none

package board_pkg;

    typedef logic [15:0] reg_addr_t;    // host register address
    typedef logic [31:0] reg_data_t;    // host register data word
    typedef logic [3:0]  axis_mask_t;   // bit 0 is axis 1

    // {neg_limit, pos_limit, home}, four bits each
    typedef logic [11:0] switch_vec_t;

    // ------------------------------------------------------
    // register offsets, address bits 3:0
    // ------------------------------------------------------
    typedef enum logic [3:0] {
        REG_STATUS     = 4'd0,
        REG_PHY_CTRL   = 4'd1,
        REG_PHY_DATA   = 4'd2,
        REG_TIMEOUT    = 4'd3,
        REG_VERSION    = 4'd4,
        REG_TEMP_SENSE = 4'd5,
        REG_DIG_OUT    = 4'd6,
        REG_FW_VERSION = 4'd7,
        REG_DIG_IN     = 4'd10
    } reg_index_e;

    // block select, matched against address bits 15:12
    localparam logic [3:0] ADDR_MAIN = 4'd0;

endpackage

`default_nettype wire

/* safety_if.sv */
// ----------------------------------------------------------
// link between the register file and the safety timers
// regs side sets the period and kicks, timers side reports
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface safety_if;
    import board_pkg::*;

    logic [15:0] wdog_period;       // ticks allowed between writes, 0 = off
    logic        wdog_kick;         // any host write
    logic        wdog_timeout;      // watchdog expired
    axis_mask_t  wdog_amp_disable;  // all ones on timeout
    axis_mask_t  mv_amp_disable;    // held during motor voltage settle

    modport regs (
        output wdog_period,
        output wdog_kick,
        input  wdog_timeout,
        input  wdog_amp_disable,
        input  mv_amp_disable
    );

    modport timers (
        input  wdog_period,
        input  wdog_kick,
        output wdog_timeout,
        output wdog_amp_disable,
        output mv_amp_disable
    );

endinterface

`default_nettype wire

/* debounce_bank.sv */
// ----------------------------------------------------------
// stability filter for slow switch inputs, one lane per bit
// a bit follows its input once it has held DEBOUNCE_CYCLES
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module debounce_bank #(
    parameter int WIDTH = 12
) (
    input  wire              sysclk,
    input  wire              reset,    // sync, active low
    input  wire [WIDTH-1:0]  raw,
    output logic [WIDTH-1:0] filt
);

    localparam int CW = $clog2(`DEBOUNCE_CYCLES + 1);
    localparam logic [CW-1:0] CNT_LAST = CW'(`DEBOUNCE_CYCLES - 1);

    logic [WIDTH-1:0] samp;            // last sample of raw
    logic [CW-1:0]    cnt [WIDTH];     // stable cycles per lane

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            samp <= '0;
            filt <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            samp <= raw;
            for (int i = 0; i < WIDTH; i++) begin
                if (raw[i] != samp[i]) begin
                    cnt[i] <= '0;                 // edge seen, start over
                end else if (cnt[i] == CNT_LAST) begin
                    filt[i] <= samp[i];           // held long enough
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* safety_timers.sv */
// ----------------------------------------------------------
// tick divider, host watchdog and motor voltage settle timer
// both timers step on the shared tick, the kick acts at once
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module safety_timers (
    input  wire       sysclk,
    input  wire       reset,     // sync, active low
    input  wire       mv_good,   // motor supply in range
    safety_if.timers  sif
);
    import board_pkg::*;

    localparam int MW = $clog2(`MV_GOOD_TICKS + 1);

    logic [`WIDTH_WATCHDOG-1:0] div;   // free running prescaler
    logic                       tick;
    logic [15:0]                wdog_count;
    logic                       wdog_flag;
    logic [MW-1:0]              mv_count;
    logic                       mv_hold;

    // ------------------------------------------------------
    // tick, one cycle every 2**WIDTH_WATCHDOG
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    assign tick = &div;

    // ------------------------------------------------------
    // watchdog, counts ticks since the last host write
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset || sif.wdog_kick) begin
            wdog_count <= '0;
            wdog_flag  <= 1'b0;
        end else if (tick && sif.wdog_period != 16'd0) begin
            if (wdog_count < sif.wdog_period) begin
                wdog_count <= wdog_count + 1'b1;
            end else begin
                wdog_flag <= 1'b1;    // host went quiet
            end
        end
    end

    assign sif.wdog_timeout     = wdog_flag;
    assign sif.wdog_amp_disable = {4{wdog_flag}};

    // ------------------------------------------------------
    // settle timer, amps off until supply is stable
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            mv_count <= '0;
            mv_hold  <= 1'b1;    // start with amps held off
        end else if (!mv_good) begin
            mv_count <= '0;      // supply dropped, any cycle
            mv_hold  <= 1'b1;
        end else if (tick) begin
            if (mv_count < MW'(`MV_GOOD_TICKS)) begin
                mv_count <= mv_count + 1'b1;
            end else begin
                mv_hold <= 1'b0;
            end
        end
    end

    assign sif.mv_amp_disable = {4{mv_hold}};

endmodule

`default_nettype wire

/* reset_sequencer.sv */
// ----------------------------------------------------------
// internal reset from the board reset and a soft request
// a soft request stretches to SOFT_RESET_CYCLES low cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module reset_sequencer (
    input  wire  sysclk,
    input  wire  reset,      // external, sync, active low
    input  wire  soft_req,   // from the register file
    output logic sys_reset   // internal, active low
);

    localparam int CW = $clog2(`SOFT_RESET_CYCLES + 1);

    logic [CW-1:0] cnt;   // remaining soft reset cycles

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            cnt       <= '0;
            sys_reset <= 1'b0;    // follow the board reset
        end else if (cnt != '0) begin
            cnt       <= cnt - 1'b1;
            sys_reset <= (cnt == CW'(1));   // release on last count
        end else if (soft_req) begin
            cnt       <= CW'(`SOFT_RESET_CYCLES);
            sys_reset <= 1'b0;
        end else begin
            sys_reset <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* board_regs.sv */
// ----------------------------------------------------------
// host register file of the board block
// masked writes to control bits, registered read port,
// sticky amplifier disables from the safety timers
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module board_regs (
    input  wire                     sysclk,
    input  wire                     reset,       // sync, active low
    // host bus
    input  wire board_pkg::reg_addr_t reg_raddr,
    input  wire board_pkg::reg_addr_t reg_waddr,
    input  wire board_pkg::reg_data_t reg_wdata,
    input  wire                     reg_wen,
    output board_pkg::reg_data_t    reg_rdata,
    // board status
    input  wire board_pkg::switch_vec_t filt,    // debounced switches
    input  wire board_pkg::axis_mask_t  fault,
    input  wire board_pkg::axis_mask_t  safety_amp_disable,
    input  wire                     relay,
    input  wire                     mv_good,
    input  wire                     v_fault,
    input  wire [3:0]               board_id,
    input  wire [15:0]              temp_sense,
    // board control
    output board_pkg::axis_mask_t   amp_disable,
    output board_pkg::axis_mask_t   dout,
    output logic                    pwr_enable,
    output logic                    relay_on,
    output logic                    soft_req,
    safety_if.regs                  sif
);
    import board_pkg::*;

    logic        wr;           // decoded write to this block
    axis_mask_t  reg_disable;  // 1 = axis held off by host
    logic [15:0] phy_ctrl;
    logic [15:0] phy_data;
    logic [15:0] wdog_period;

    assign wr = reg_wen && reg_waddr[15:12] == ADDR_MAIN && reg_waddr[7:4] == 4'd0;

    assign sif.wdog_kick   = reg_wen;     // any host write feeds the dog
    assign sif.wdog_period = wdog_period;

    assign amp_disable = reg_disable | sif.mv_amp_disable;

    // ------------------------------------------------------
    // writes, else read mux and sticky disables
    // ------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_rdata   <= '0;
            reg_disable <= 4'hf;          // all axes off
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            dout        <= '0;
            soft_req    <= 1'b0;
            phy_ctrl    <= '0;
            phy_data    <= '0;
            wdog_period <= 16'hffff;
        end else if (wr) begin
            soft_req <= 1'b0;
            case (reg_index_e'(reg_waddr[3:0]))
                REG_STATUS: begin
                    // enable needs power already on
                    for (int i = 0; i < 4; i++) begin
                        reg_disable[i] <= !pwr_enable ||
                            (reg_wdata[8+i] ? !reg_wdata[i] : reg_disable[i]);
                    end
                    if (reg_wdata[17]) relay_on <= reg_wdata[16];
                    if (reg_wdata[19]) pwr_enable <= reg_wdata[18];
                    soft_req <= reg_wdata[21] && reg_wdata[20];
                end
                REG_PHY_CTRL: phy_ctrl <= reg_wdata[15:0];
                REG_PHY_DATA: phy_data <= reg_wdata[15:0];
                REG_TIMEOUT:  wdog_period <= reg_wdata[15:0];
                REG_DIG_OUT: begin
                    for (int i = 0; i < 4; i++) begin
                        if (reg_wdata[8+i]) dout[i] <= reg_wdata[i];
                    end
                end
                default: ;                // read-only offsets
            endcase
        end else begin
            soft_req <= 1'b0;
            case (reg_index_e'(reg_raddr[3:0]))
                REG_STATUS: reg_rdata <= {
                    4'd4, board_id,                        // axes, board id
                    sif.wdog_timeout, 3'd0,
                    mv_good, pwr_enable, !relay, relay_on,
                    4'd0, fault,
                    safety_amp_disable, ~reg_disable       // 1 = enabled
                };
                REG_PHY_CTRL:   reg_rdata <= {16'd0, phy_ctrl};
                REG_PHY_DATA:   reg_rdata <= {16'd0, phy_data};
                REG_TIMEOUT:    reg_rdata <= {16'd0, wdog_period};
                REG_VERSION:    reg_rdata <= `BOARD_VERSION;
                REG_TEMP_SENSE: reg_rdata <= {16'd0, temp_sense};
                REG_DIG_OUT:    reg_rdata <= {28'd0, dout};
                REG_FW_VERSION: reg_rdata <= `FW_VERSION;
                REG_DIG_IN:     reg_rdata <= {15'd0, v_fault, dout, filt};
                default:        reg_rdata <= '0;
            endcase
            // safety trips latch until the host re-enables
            if (sif.wdog_amp_disable != '0 || safety_amp_disable != '0) begin
                reg_disable <= reg_disable | sif.wdog_amp_disable | safety_amp_disable;
            end
        end
    end

endmodule

`default_nettype wire

/* board_ctrl_top.sv */
// ----------------------------------------------------------
// board register block top level, plain host and board ports
// reset sequencer, switch filter, register file, timers
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_top (
    input  wire                         sysclk,
    input  wire                         reset,   // sync, active low
    // board inputs
    input  wire board_pkg::axis_mask_t  neg_limit,
    input  wire board_pkg::axis_mask_t  pos_limit,
    input  wire board_pkg::axis_mask_t  home,
    input  wire board_pkg::axis_mask_t  fault,
    input  wire board_pkg::axis_mask_t  safety_amp_disable,
    input  wire                         relay,
    input  wire                         mv_good,
    input  wire                         v_fault,
    input  wire [3:0]                   board_id,
    input  wire [15:0]                  temp_sense,
    // host bus
    input  wire board_pkg::reg_addr_t   reg_raddr,
    input  wire board_pkg::reg_addr_t   reg_waddr,
    input  wire board_pkg::reg_data_t   reg_wdata,
    input  wire                         reg_wen,
    output board_pkg::reg_data_t        reg_rdata,
    // board outputs
    output board_pkg::axis_mask_t       amp_disable,
    output board_pkg::axis_mask_t       dout,
    output logic                        pwr_enable,
    output logic                        relay_on
);
    import board_pkg::*;

    logic        sys_reset;   // internal reset, active low
    logic        soft_req;
    switch_vec_t filt;

    safety_if i_safety_if ();

    reset_sequencer i_reset_sequencer (
        .sysclk    (sysclk),
        .reset     (reset),
        .soft_req  (soft_req),
        .sys_reset (sys_reset)
    );

    debounce_bank #(.WIDTH($bits(switch_vec_t))) i_debounce_bank (
        .sysclk (sysclk),
        .reset  (sys_reset),
        .raw    ({neg_limit, pos_limit, home}),
        .filt   (filt)
    );

    board_regs i_board_regs (
        .sysclk             (sysclk),
        .reset              (sys_reset),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .reg_rdata          (reg_rdata),
        .filt               (filt),
        .fault              (fault),
        .safety_amp_disable (safety_amp_disable),
        .relay              (relay),
        .mv_good            (mv_good),
        .v_fault            (v_fault),
        .board_id           (board_id),
        .temp_sense         (temp_sense),
        .amp_disable        (amp_disable),
        .dout               (dout),
        .pwr_enable         (pwr_enable),
        .relay_on           (relay_on),
        .soft_req           (soft_req),
        .sif                (i_safety_if.regs)
    );

    safety_timers i_safety_timers (
        .sysclk  (sysclk),
        .reset   (sys_reset),
        .mv_good (mv_good),
        .sif     (i_safety_if.timers)
    );

endmodule

`default_nettype wire

/* tb_board_ctrl.sv */
// ----------------------------------------------------------
// testbench for the board register block
// random host traffic from an LCG, checked against a model
// of the control registers, switch filter and safety timers
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module tb_board_ctrl;
    import board_pkg::*;

    localparam int CLK_NS   = 8;
    localparam int TICK     = 1 << `WIDTH_WATCHDOG;   // sysclk cycles per tick
    localparam int N_WRITES = 200;
    localparam int N_SWITCH = 16;
    // rough length of all phases, in cycles
    localparam int RUN_CYCLES = 60 + (`MV_GOOD_TICKS + 2) * TICK + N_WRITES * 12
        + N_SWITCH * (4 * `DEBOUNCE_CYCLES + 16) + 10 * TICK + 60
        + (`MV_GOOD_TICKS + 4) * TICK + `SOFT_RESET_CYCLES + 60;

    logic        sysclk, reset, relay, mv_good, v_fault, reg_wen;
    logic        pwr_enable, relay_on;
    axis_mask_t  neg_limit, pos_limit, home, fault, safety_amp_disable;
    axis_mask_t  amp_disable, dout;
    logic [3:0]  board_id;
    logic [15:0] temp_sense;
    reg_addr_t   reg_raddr, reg_waddr;
    reg_data_t   reg_wdata, reg_rdata;

    // ---------------- model state -----------------------------
    axis_mask_t  m_dis, m_dout;
    logic        m_pwr, m_relay, m_timeout;
    logic [15:0] m_phy_ctrl, m_phy_data, m_period;
    switch_vec_t m_filt;
    logic [31:0] lcg_state = 32'd17;

    board_ctrl_top i_board_ctrl_top (.*);

    always #(CLK_NS / 2) sysclk = ~sysclk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);   // fold weak low bits
    endfunction

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string what, input reg_data_t got, input reg_data_t exp);
        if (got !== exp)
            stop_on_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
    endtask

    task automatic check_mask(input string what, input axis_mask_t got, input axis_mask_t exp);
        if (got !== exp)
            stop_on_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_on_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
    endtask

    task automatic model_reset();
        m_dis      = 4'hf;       // all axes off
        m_dout     = '0;
        m_pwr      = 1'b0;
        m_relay    = 1'b0;
        m_timeout  = 1'b0;
        m_phy_ctrl = '0;
        m_phy_data = '0;
        m_period   = 16'hffff;
    endtask

    task automatic model_write(input logic [3:0] off, input reg_data_t d);
        case (off)
            4'd0: begin
                for (int i = 0; i < 4; i++) begin
                    if (!m_pwr) m_dis[i] = 1'b1;           // no power, no enable
                    else if (d[8+i]) m_dis[i] = !d[i];
                end
                if (d[17]) m_relay = d[16];
                if (d[19]) m_pwr = d[18];
            end
            4'd1: m_phy_ctrl = d[15:0];
            4'd2: m_phy_data = d[15:0];
            4'd3: m_period = d[15:0];
            4'd6: begin
                for (int i = 0; i < 4; i++) begin
                    if (d[8+i]) m_dout[i] = d[i];          // mask over value
                end
            end
            default: ;
        endcase
    endtask

    function automatic reg_data_t expected_word(input logic [3:0] off);
        case (off)
            4'd0:  return {4'd4, board_id, m_timeout, 3'd0, mv_good, m_pwr, !relay,
                           m_relay, 4'd0, fault, safety_amp_disable, ~m_dis};
            4'd1:  return {16'd0, m_phy_ctrl};
            4'd2:  return {16'd0, m_phy_data};
            4'd3:  return {16'd0, m_period};
            4'd4:  return `BOARD_VERSION;
            4'd5:  return {16'd0, temp_sense};
            4'd6:  return {28'd0, m_dout};
            4'd7:  return `FW_VERSION;
            4'd10: return {15'd0, v_fault, m_dout, m_filt};
            default: return '0;                            // unknown offset
        endcase
    endfunction

    task automatic write_addr(input reg_addr_t a, input reg_data_t d);
        @(posedge sysclk);
        reg_waddr <= a;
        reg_wdata <= d;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
        m_timeout = 1'b0;                                  // every strobe kicks
        if (a[15:12] == ADDR_MAIN && a[7:4] == 4'd0) model_write(a[3:0], d);
    endtask

    task automatic write_reg(input logic [3:0] off, input reg_data_t d);
        write_addr({ADDR_MAIN, 8'd0, off}, d);
    endtask

    task automatic read_check(input logic [3:0] off);
        logic [31:0] r;
        r = next_rand();
        @(posedge sysclk);
        reg_raddr <= {r[15:4], off};                       // upper bits ignored
        @(posedge sysclk);
        @(negedge sysclk);
        check_word($sformatf("read of offset %0d", off), reg_rdata, expected_word(off));
    endtask

    task automatic check_outputs(input axis_mask_t mv_dis);
        @(negedge sysclk);
        check_mask("amp_disable", amp_disable, m_dis | mv_dis);
        check_mask("dout", dout, m_dout);
        check_bit("pwr_enable", pwr_enable, m_pwr);
        check_bit("relay_on", relay_on, m_relay);
    endtask

    task automatic wait_amp(input axis_mask_t want, input int limit, output int cycles);
        cycles = 0;
        @(negedge sysclk);
        while (amp_disable !== want) begin
            if (cycles >= limit)
                stop_on_failure($sformatf("amp_disable never reached %h within %0d cycles",
                    want, limit));
            @(negedge sysclk);
            cycles++;
        end
    endtask

    task automatic check_reset_values();
        check_outputs(4'hf);
        for (int o = 0; o < 8; o++) read_check(o[3:0]);
    endtask

    // ---------------- stimulus --------------------------------
    initial begin
        logic [31:0] r, d, s;
        reg_addr_t   a;
        logic [3:0]  off;
        int          p, k, cycles;
        sysclk             = 1'b0;
        reset              = 1'b0;
        {neg_limit, pos_limit, home} = '0;
        fault              = '0;
        safety_amp_disable = '0;
        relay              = 1'b0;
        mv_good            = 1'b1;
        v_fault            = 1'b0;
        board_id           = 4'd3;
        temp_sense         = 16'h1234;
        reg_raddr          = 16'h000f;    // unknown offset, reads zero
        reg_waddr          = '0;
        reg_wdata          = '0;
        reg_wen            = 1'b0;
        model_reset();
        m_filt = '0;
        repeat (16) @(posedge sysclk);
        reset <= 1'b1;
        @(posedge sysclk);                // internal reset still low here
        @(negedge sysclk);
        check_word("reg_rdata after reset", reg_rdata, '0);
        check_reset_values();
        repeat ((`MV_GOOD_TICKS + 2) * TICK) @(posedge sysclk);   // settle

        // random masked writes, some outside the block
        for (int n = 0; n < N_WRITES; n++) begin
            r = next_rand();
            d = next_rand();
            s = next_rand();
            off = r[3:0] % 4'd11;
            if (off == 4'd0) d[21] = 1'b0;                 // no soft reset here
            if (off == 4'd3) d[15] = 1'b1;                 // long period
            a = {ADDR_MAIN, r[11:8], 4'd0, off};
            if (r[30:28] == 3'd0) a[7:4] = r[7:4] | 4'd1;
            if (r[30:28] == 3'd1) a[15:12] = r[27:24] | 4'd1;
            @(posedge sysclk);
            fault      <= s[3:0];
            board_id   <= s[7:4];
            relay      <= s[8];
            v_fault    <= s[9];
            temp_sense <= s[31:16];
            write_addr(a, d);
            read_check(off);
            read_check(s[13:10]);
            check_outputs(4'h0);
        end

        // debounce, long levels pass and short pulses do not
        for (int n = 0; n < N_SWITCH; n++) begin
            r = next_rand();
            @(posedge sysclk);
            {neg_limit, pos_limit, home} <= r[11:0];
            repeat (2 * `DEBOUNCE_CYCLES) @(posedge sysclk);
            m_filt = r[11:0];
            read_check(4'd10);
            k = 1 + r[19:16] % (`DEBOUNCE_CYCLES - 1);
            s = next_rand();
            @(posedge sysclk);
            {neg_limit, pos_limit, home} <= s[11:0];
            repeat (k) @(posedge sysclk);
            {neg_limit, pos_limit, home} <= m_filt;
            repeat (2 * `DEBOUNCE_CYCLES) @(posedge sysclk);
            read_check(4'd10);
        end

        // ---------------- host watchdog ---------------------------
        write_reg(4'd0, 32'h000c_0000);    // power on
        write_reg(4'd0, 32'h0000_0f0f);    // all axes on
        check_outputs(4'h0);
        p = 1 + next_rand() % 6;
        write_reg(4'd3, p);
        for (int n = 0; n < (p + 2) * TICK / 2; n++) read_check(4'd4);   // reads only
        m_timeout = 1'b1;
        m_dis     = 4'hf;
        read_check(4'd0);
        check_outputs(4'h0);
        write_reg(4'd3, 32'h0000_ffff);    // kick clears the flag
        read_check(4'd0);
        check_outputs(4'h0);
        write_reg(4'd0, 32'h0000_0f0f);
        r = next_rand();
        s = (r[3:0] == 4'd0) ? 32'd4 : r[3:0];
        @(posedge sysclk);
        safety_amp_disable <= s[3:0];
        @(posedge sysclk);
        safety_amp_disable <= 4'd0;
        m_dis = m_dis | s[3:0];            // one cycle trip sticks
        read_check(4'd0);
        check_outputs(4'h0);

        // motor voltage drop and settle
        write_reg(4'd0, 32'h0000_0f0f);
        @(posedge sysclk);
        mv_good <= 1'b0;
        wait_amp(4'hf, 2 * TICK, cycles);
        read_check(4'd0);
        @(posedge sysclk);
        mv_good <= 1'b1;
        wait_amp(m_dis, (`MV_GOOD_TICKS + 2) * TICK, cycles);
        if (cycles < (`MV_GOOD_TICKS - 1) * TICK)
            stop_on_failure($sformatf("error at %0t ns: axes released after %0d cycles",
                $time, cycles));
        check_outputs(4'h0);

        // soft reset from a busy state
        write_reg(4'd6, 32'h0000_0f05);
        write_reg(4'd0, 32'h0003_0000);    // relay on
        write_reg(4'd1, next_rand());
        write_reg(4'd0, 32'h0030_0000);
        model_reset();
        repeat (`SOFT_RESET_CYCLES + 8) @(posedge sysclk);
        check_reset_values();
        $display("No errors");
        $finish;
    end

    initial begin
        #(2 * RUN_CYCLES * CLK_NS);
        $display("Errors found");
        $fatal(1, "run did not finish within %0d cycles", 2 * RUN_CYCLES);
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
board_pkg.sv
safety_if.sv
debounce_bank.sv
safety_timers.sv
reset_sequencer.sv
board_regs.sv
board_ctrl_top.sv
tb_board_ctrl.sv
